/* hw/lunar_rescue_pkg.sv */
package lunar_rescue_pkg;

	// horizontal raster, in pixel clocks.
	localparam logic [8:0] h_total_c      = 9'd320;
	localparam logic [8:0] h_active_c     = 9'd256;
	localparam logic [8:0] h_sync_start_c = 9'd272;
	localparam logic [8:0] h_sync_end_c   = 9'd304;

	// vertical raster, in lines.
	localparam logic [8:0] v_total_c      = 9'd262;
	localparam logic [8:0] v_active_c     = 9'd224;
	localparam logic [8:0] v_sync_start_c = 9'd236;
	localparam logic [8:0] v_sync_end_c   = 9'd239;

	// byte address is line * 32 + column / 8.
	localparam int vram_addr_w_c = 13;

	localparam logic [7:0] audio_weight_c = 8'd40;

	typedef struct packed {
		logic r;
		logic g;
		logic b;
	} rgb_t;

	localparam rgb_t red_c   = '{r: 1'b1, g: 1'b0, b: 1'b0};
	localparam rgb_t green_c = '{r: 1'b0, g: 1'b1, b: 1'b0};
	localparam rgb_t cyan_c  = '{r: 1'b0, g: 1'b1, b: 1'b1};
	localparam rgb_t white_c = '{r: 1'b1, g: 1'b1, b: 1'b1};
	localparam rgb_t black_c = '{r: 1'b0, g: 1'b0, b: 1'b0};

	// cellophane strips, one per 32 lines from the top.
	localparam rgb_t band_color_c [8] = '{
		red_c, white_c, white_c, green_c, green_c, white_c, cyan_c, white_c
	};

	typedef struct packed {
		logic [25:0] reserved_hi;
		logic        overlay_off;
		logic [1:0]  scanlines;
		logic        rotate;
		logic        reserved_lo;
		logic        soft_reset;
	} status_cfg_t;

	typedef union packed {
		logic [31:0] raw;
		status_cfg_t cfg;
	} status_u;

endpackage

/* hw/video_if.sv */
`timescale 1ns/1ps

interface video_if;

	logic [8:0] hcount;
	logic [8:0] vcount;
	logic       active;
	logic       hsync;
	logic       vsync;

	modport src (
		output hcount, vcount, active, hsync, vsync
	);

	modport fetch (
		input hcount, vcount, active
	);

	modport disp (
		input vcount, active, hsync, vsync
	);

endinterface

/* hw/video_timing.sv */
`timescale 1ns/1ps

module video_timing #(
	parameter logic [8:0] H_TOTAL      = lunar_rescue_pkg::h_total_c,
	parameter logic [8:0] H_ACTIVE     = lunar_rescue_pkg::h_active_c,
	parameter logic [8:0] H_SYNC_START = lunar_rescue_pkg::h_sync_start_c,
	parameter logic [8:0] H_SYNC_END   = lunar_rescue_pkg::h_sync_end_c,
	parameter logic [8:0] V_TOTAL      = lunar_rescue_pkg::v_total_c,
	parameter logic [8:0] V_ACTIVE     = lunar_rescue_pkg::v_active_c,
	parameter logic [8:0] V_SYNC_START = lunar_rescue_pkg::v_sync_start_c,
	parameter logic [8:0] V_SYNC_END   = lunar_rescue_pkg::v_sync_end_c
) (
	input  logic   clk_sys,
	input  logic   rst_n,
	video_if.src   vid
);

	logic [8:0] hc;
	logic [8:0] vc;
	logic       h_wrap;

	assign h_wrap = (hc == H_TOTAL - 9'd1);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hc <= '0;
			vc <= '0;
		end else begin
			hc <= h_wrap ? 9'd0 : hc + 9'd1;
			if (h_wrap) begin
				vc <= (vc == V_TOTAL - 9'd1) ? 9'd0 : vc + 9'd1;
			end
		end
	end

	// outputs are one register behind the counters.
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vid.hcount <= '0;
			vid.vcount <= '0;
			vid.active <= 1'b0;
			vid.hsync  <= 1'b1;
			vid.vsync  <= 1'b1;
		end else begin
			vid.hcount <= hc;
			vid.vcount <= vc;
			vid.active <= (hc < H_ACTIVE) && (vc < V_ACTIVE);
			vid.hsync  <= !((hc >= H_SYNC_START) && (hc < H_SYNC_END));
			// vsync only changes on the leading edge of hsync.
			if (hc == H_SYNC_START) begin
				vid.vsync <= !((vc >= V_SYNC_START) && (vc < V_SYNC_END));
			end
		end
	end

endmodule

/* hw/video_ram.sv */
`timescale 1ns/1ps

module video_ram #(
	parameter int DEPTH = 7168
) (
	input  logic                                       clk_sys,
	input  logic                                       we,
	input  logic [lunar_rescue_pkg::vram_addr_w_c-1:0] waddr,
	input  logic [7:0]                                 wdata,
	input  logic [lunar_rescue_pkg::vram_addr_w_c-1:0] raddr,
	output logic [7:0]                                 rdata
);

	logic [7:0] mem [0:DEPTH-1];

	// host side.
	always_ff @(posedge clk_sys) begin
		if (we && (int'(waddr) < DEPTH)) begin
			mem[waddr] <= wdata;
		end
	end

	// video side, one cycle read latency.
	always_ff @(posedge clk_sys) begin
		if (int'(raddr) < DEPTH) begin
			rdata <= mem[raddr];
		end else begin
			rdata <= 8'h00;
		end
	end

endmodule

/* hw/pixel_fetch.sv */
`timescale 1ns/1ps

module pixel_fetch #(
	parameter logic [8:0] H_ACTIVE = lunar_rescue_pkg::h_active_c,
	parameter logic [8:0] V_ACTIVE = lunar_rescue_pkg::v_active_c
) (
	input  logic                                       clk_sys,
	input  logic                                       rst_n,
	video_if.fetch                                     vid,
	output logic [lunar_rescue_pkg::vram_addr_w_c-1:0] ram_addr,
	input  logic [7:0]                                 ram_data,
	output logic                                       pixel
);

	localparam int bytes_per_line_c = int'(H_ACTIVE) / 8;

	logic [2:0] bit_sel;
	logic       active_q;
	logic       in_pic;

	assign in_pic = (vid.hcount < H_ACTIVE) && (vid.vcount < V_ACTIVE);

	always_comb begin
		logic [31:0] addr_full;
		addr_full = int'(vid.vcount) * bytes_per_line_c + int'(vid.hcount >> 3);
		// park the address outside the picture.
		if (in_pic) begin
			ram_addr = addr_full[lunar_rescue_pkg::vram_addr_w_c-1:0];
		end else begin
			ram_addr = '0;
		end
	end

	// bit index follows the ram read by one cycle.
	always_ff @(posedge clk_sys) begin
		bit_sel <= vid.hcount[2:0];
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			active_q <= 1'b0;
		end else begin
			active_q <= vid.active;
		end
	end

	// bit 0 is the leftmost pixel of the byte.
	assign pixel = active_q ? ram_data[bit_sel] : 1'b0;

endmodule

/* hw/color_overlay.sv */
`timescale 1ns/1ps

module color_overlay #(
	parameter logic [8:0] V_ACTIVE = lunar_rescue_pkg::v_active_c
) (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   overlay_en,
	input  logic                   pixel,
	video_if.disp                  vid,
	output lunar_rescue_pkg::rgb_t rgb,
	output logic                   hs,
	output logic                   vs
);

	logic [8:0]             vcount_d;
	logic                   active_d;
	logic                   hsync_d;
	logic                   vsync_d;
	logic [2:0]             band;
	lunar_rescue_pkg::rgb_t color;

	// first stage lines up with the fetched pixel.
	always_ff @(posedge clk_sys) begin
		vcount_d <= vid.vcount;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			active_d <= 1'b0;
			hsync_d  <= 1'b1;
			vsync_d  <= 1'b1;
		end else begin
			active_d <= vid.active;
			hsync_d  <= vid.hsync;
			vsync_d  <= vid.vsync;
		end
	end

	// lines below the picture fall back to band 0.
	assign band = (vcount_d < V_ACTIVE) ? vcount_d[7:5] : 3'd0;

	always_comb begin
		if (!pixel || !active_d) begin
			color = lunar_rescue_pkg::black_c;
		end else if (overlay_en) begin
			color = lunar_rescue_pkg::band_color_c[band];
		end else begin
			color = lunar_rescue_pkg::white_c;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rgb <= lunar_rescue_pkg::black_c;
			hs  <= 1'b1;
			vs  <= 1'b1;
		end else begin
			rgb <= color;
			hs  <= hsync_d;
			vs  <= vsync_d;
		end
	end

endmodule

/* hw/audio_out.sv */
`timescale 1ns/1ps

module audio_out (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic [5:0] sound_ctrl,
	output logic       dac_bit
);

	logic [7:0] mix;
	logic [7:0] level;
	logic [8:0] acc;

	// each active sound adds the same share.
	always_comb begin
		mix = 8'd0;
		for (int i = 0; i < 6; i++) begin
			if (sound_ctrl[i]) begin
				mix = mix + lunar_rescue_pkg::audio_weight_c;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			level <= 8'd0;
		end else begin
			level <= mix;
		end
	end

	// first order sigma-delta, the carry is the output bit.
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc <= 9'd0;
		end else begin
			acc <= {1'b0, acc[7:0]} + {1'b0, level};
		end
	end

	assign dac_bit = acc[8];

endmodule

/* hw/lunar_rescue_top.sv */
`timescale 1ns/1ps

module lunar_rescue_top #(
	parameter logic [8:0] H_TOTAL      = lunar_rescue_pkg::h_total_c,
	parameter logic [8:0] H_ACTIVE     = lunar_rescue_pkg::h_active_c,
	parameter logic [8:0] H_SYNC_START = lunar_rescue_pkg::h_sync_start_c,
	parameter logic [8:0] H_SYNC_END   = lunar_rescue_pkg::h_sync_end_c,
	parameter logic [8:0] V_TOTAL      = lunar_rescue_pkg::v_total_c,
	parameter logic [8:0] V_ACTIVE     = lunar_rescue_pkg::v_active_c,
	parameter logic [8:0] V_SYNC_START = lunar_rescue_pkg::v_sync_start_c,
	parameter logic [8:0] V_SYNC_END   = lunar_rescue_pkg::v_sync_end_c
) (
	input  logic                                       clk_sys,
	input  logic                                       rst_n,
	input  logic [31:0]                                status,
	input  logic                                       host_we,
	input  logic [lunar_rescue_pkg::vram_addr_w_c-1:0] host_addr,
	input  logic [7:0]                                 host_data,
	input  logic [5:0]                                 sound_ctrl,
	output logic                                       vga_r,
	output logic                                       vga_g,
	output logic                                       vga_b,
	output logic                                       vga_hs,
	output logic                                       vga_vs,
	output logic                                       audio_l,
	output logic                                       audio_r,
	output logic                                       led
);

	localparam int vram_depth_c = (int'(H_ACTIVE) / 8) * int'(V_ACTIVE);

	lunar_rescue_pkg::status_u                  st;
	lunar_rescue_pkg::rgb_t                     rgb;
	logic                                       blk_rst_n;
	logic [lunar_rescue_pkg::vram_addr_w_c-1:0] ram_addr;
	logic [7:0]                                 ram_data;
	logic                                       pixel;

	assign st.raw    = status;
	// menu reset acts like the board reset.
	assign blk_rst_n = rst_n & ~st.cfg.soft_reset;

	video_if vid ();

	video_timing #(
		.H_TOTAL      (H_TOTAL),
		.H_ACTIVE     (H_ACTIVE),
		.H_SYNC_START (H_SYNC_START),
		.H_SYNC_END   (H_SYNC_END),
		.V_TOTAL      (V_TOTAL),
		.V_ACTIVE     (V_ACTIVE),
		.V_SYNC_START (V_SYNC_START),
		.V_SYNC_END   (V_SYNC_END)
	) video_timing (
		.clk_sys (clk_sys),
		.rst_n   (blk_rst_n),
		.vid     (vid.src)
	);

	video_ram #(.DEPTH(vram_depth_c)) video_ram (
		.clk_sys (clk_sys),
		.we      (host_we),
		.waddr   (host_addr),
		.wdata   (host_data),
		.raddr   (ram_addr),
		.rdata   (ram_data)
	);

	pixel_fetch #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) pixel_fetch (
		.clk_sys  (clk_sys),
		.rst_n    (blk_rst_n),
		.vid      (vid.fetch),
		.ram_addr (ram_addr),
		.ram_data (ram_data),
		.pixel    (pixel)
	);

	color_overlay #(.V_ACTIVE(V_ACTIVE)) color_overlay (
		.clk_sys    (clk_sys),
		.rst_n      (blk_rst_n),
		.overlay_en (~st.cfg.overlay_off),
		.pixel      (pixel),
		.vid        (vid.disp),
		.rgb        (rgb),
		.hs         (vga_hs),
		.vs         (vga_vs)
	);

	audio_out audio_out (
		.clk_sys    (clk_sys),
		.rst_n      (blk_rst_n),
		.sound_ctrl (sound_ctrl),
		.dac_bit    (audio_l)
	);

	assign vga_r   = rgb.r;
	assign vga_g   = rgb.g;
	assign vga_b   = rgb.b;
	assign audio_r = audio_l;
	assign led     = 1'b1;

endmodule

/* tb/lunar_rescue_checker.sv */
`timescale 1ns/1ps

module lunar_rescue_checker (
	input logic clk_sys,
	input logic blk_rst_n,
	input logic vga_r,
	input logic vga_g,
	input logic vga_b,
	input logic vga_hs,
	input logic vga_vs,
	input logic audio_l
);

	logic [7:0] low_run;
	int         fails = 0;

	// length of the current hsync pulse so far.
	always_ff @(posedge clk_sys) begin
		if (!blk_rst_n || vga_hs) begin
			low_run <= 8'd0;
		end else begin
			low_run <= low_run + 8'd1;
		end
	end

	assert property (@(posedge clk_sys) disable iff (!blk_rst_n)
		$rose(vga_hs) |-> low_run == 8'd32)
		else begin
			$error("hsync pulse is not 32 cycles wide");
			fails++;
		end

	assert property (@(posedge clk_sys) disable iff (!blk_rst_n)
		$fell(vga_vs) |-> $fell(vga_hs))
		else begin
			$error("vsync fell away from an hsync fall");
			fails++;
		end

	assert property (@(posedge clk_sys) disable iff (!blk_rst_n)
		!vga_hs |-> !(vga_r || vga_g || vga_b))
		else begin
			$error("colour present during hsync");
			fails++;
		end

	// idle levels one cycle after the block reset.
	assert property (@(posedge clk_sys) !blk_rst_n |=> vga_hs && vga_vs && !audio_l)
		else begin
			$error("outputs not idle after reset");
			fails++;
		end

endmodule

/* tb/tb_lunar_rescue.sv */
`timescale 1ns/1ps

module tb_lunar_rescue;

	localparam int frame_c = 320 * 262;

	logic        clk_sys;
	logic        rst_n;
	logic [31:0] status;
	logic        host_we;
	logic [12:0] host_addr;
	logic [7:0]  host_data;
	logic [5:0]  sound_ctrl;
	logic        vga_r;
	logic        vga_g;
	logic        vga_b;
	logic        vga_hs;
	logic        vga_vs;
	logic        audio_l;
	logic        audio_r;
	logic        led;

	lunar_rescue_pkg::status_u st;
	logic [7:0] model_mem [0:7167];
	logic       overlay_on;
	logic       timed_out;
	int         seed;
	int         errors;
	int         test_err;
	int         tests_run;
	int         tests_failed;
	int         wr_q[$];
	int         ovl_q[$];
	int         snd_q[$];

	lunar_rescue_top dut0 (.*);

	bind lunar_rescue_top lunar_rescue_checker chk0 (.*);

	always #10 clk_sys = ~clk_sys;

	// lit pixel colour as {r, g, b}.
	function automatic logic [2:0] exp_rgb(input int x, input int y);
		logic [7:0] b;
		if (x >= 256 || y >= 224) begin
			return 3'b000;
		end
		b = model_mem[y * 32 + x / 8];
		if (!b[x % 8]) begin
			return 3'b000;
		end else if (!overlay_on) begin
			return 3'b111;
		end
		// cellophane strips, 32 lines each.
		case (y / 32)
			0: return 3'b100;
			3, 4: return 3'b010;
			6: return 3'b011;
			default: return 3'b111;
		endcase
	endfunction

	task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] got,
		input int x, input int y);
		assert (got === exp) else begin
			errors++;
			test_err++;
			$display("ERR %s expected 0x%0h observed 0x%0h at x=%0d y=%0d", name, exp, got, x, y);
		end
	endtask

	task automatic host_write(input int addr, input logic [7:0] data);
		@(posedge clk_sys);
		host_we <= 1'b1;
		host_addr <= addr[12:0];
		host_data <= data;
		model_mem[addr] = data;
	endtask

	task automatic wait_vs_fall(output bit found);
		logic prev;
		found = 1'b0;
		@(negedge clk_sys);
		prev = vga_vs;
		for (int i = 0; i < 2 * frame_c && !found; i++) begin
			@(negedge clk_sys);
			found = prev && !vga_vs;
			prev = vga_vs;
		end
		if (!found) begin
			$display("timeout: no falling edge on vga_vs within two frames");
			timed_out = 1'b1;
			errors++;
			test_err++;
		end
	endtask

	// walks the raster from a known position, one sample per clock.
	task automatic check_cycles(input int x0, input int y0, input int n, input bit full);
		int x;
		int y;
		x = x0;
		y = y0;
		for (int i = 0; i < n && test_err < 16; i++) begin
			if (i > 0) begin
				@(negedge clk_sys);
				x = (x + 1) % 320;
				y = (x == 0) ? (y + 1) % 262 : y;
			end
			check_val("vga_hs", !(x >= 272 && x < 304), vga_hs, x, y);
			check_val("vga_vs", !((y == 236 && x >= 272) || y == 237 || y == 238
				|| (y == 239 && x < 272)), vga_vs, x, y);
			if (full || x >= 256 || y >= 224) begin
				check_val("{vga_r, vga_g, vga_b}", exp_rgb(x, y), {vga_r, vga_g, vga_b}, x, y);
			end
		end
		if (test_err >= 16) begin
			$display("too many mismatches, raster check stopped early");
		end
	endtask

	task automatic audio_test(input logic [5:0] ctrl, input int level);
		int ones;
		ones = 0;
		@(posedge clk_sys);
		sound_ctrl <= ctrl;
		// level register, then accumulator.
		repeat (3) @(posedge clk_sys);
		check_val("test data level", 40 * $countones(ctrl), level, -1, -1);
		for (int i = 0; i < 256; i++) begin
			@(negedge clk_sys);
			ones += audio_l;
			check_val("audio_r", audio_l, audio_r, i, -1);
		end
		assert (ones >= level - 1 && ones <= level + 1) else begin
			errors++;
			test_err++;
			$display("ERR audio_l ones expected 0x%0h observed 0x%0h", level, ones);
		end
	endtask

	task automatic finish_test(input string name);
		if (test_err == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, test_err);
			tests_failed++;
		end
		tests_run++;
		test_err = 0;
	endtask

	initial begin
		logic [31:0] r;
		string       kind;
		string       line;
		int          fd;
		int          a;
		int          b;
		bit          found;
		clk_sys = 1'b0;
		rst_n = 1'b0;
		st.raw = '0;
		status = '0;
		host_we = 1'b0;
		host_addr = '0;
		host_data = '0;
		sound_ctrl = '0;
		seed = 4;
		overlay_on = 1'b1;
		timed_out = 1'b0;
		fd = $fopen("tb/lunar_rescue_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/lunar_rescue_testdata.txt");
			errors++;
		end else begin
			while ($fscanf(fd, "%s", kind) == 1) begin
				if (kind == "w" && $fscanf(fd, "%h %h", a, b) == 2) begin
					wr_q.push_back(a * 256 + b);
				end else if (kind == "o" && $fscanf(fd, "%h", a) == 1) begin
					ovl_q.push_back(a);
				end else if (kind == "s" && $fscanf(fd, "%h %h", a, b) == 2) begin
					snd_q.push_back(a * 256 + b);
				end else begin
					void'($fgets(line, fd));
				end
			end
			$fclose(fd);
		end

		repeat (5) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(negedge clk_sys);
		// last reset edge, three samples ahead of column 0.
		check_cycles(317, 261, 2 * frame_c, 1'b0);
		// board led is tied on.
		check_val("led", 8'h01, led, -1, -1);
		finish_test("reset and raster");

		for (int i = 0; i < 7168; i++) begin
			host_write(i, 8'h00);
		end
		foreach (wr_q[i]) begin
			host_write(wr_q[i] / 256, wr_q[i] % 256);
		end
		for (int i = 0; i < 64; i++) begin
			r = $random(seed);
			host_write(r % 7168, r[23:16]);
		end
		@(posedge clk_sys);
		host_we <= 1'b0;

		foreach (ovl_q[i]) begin
			if (!timed_out) begin
				overlay_on = (ovl_q[i] != 0);
				st.cfg.overlay_off = !overlay_on;
				@(posedge clk_sys);
				status <= st.raw;
				wait_vs_fall(found);
				if (found) begin
					check_cycles(272, 236, frame_c, 1'b1);
				end
				finish_test(overlay_on ? "overlay on" : "overlay off");
			end
		end

		if (!timed_out) begin
			st.cfg.soft_reset = 1'b1;
			@(posedge clk_sys);
			status <= st.raw;
			st.cfg.soft_reset = 1'b0;
			for (int i = 0; i < 10; i++) begin
				@(posedge clk_sys);
				if (i == 9) begin
					status <= st.raw;
				end
				@(negedge clk_sys);
				check_val("{vga_hs, vga_vs, vga_r, vga_g, vga_b}", 8'h18,
					{vga_hs, vga_vs, vga_r, vga_g, vga_b}, -1, -1);
			end
			@(negedge clk_sys);
			check_cycles(318, 261, 2 * frame_c, 1'b1);
			finish_test("soft reset");
		end

		foreach (snd_q[i]) begin
			audio_test(snd_q[i] / 256, snd_q[i] % 256);
		end
		finish_test("audio");

		if (dut0.chk0.fails != 0) begin
			$display("bound checker reported %0d assertion failures", dut0.chk0.fails);
			errors += dut0.chk0.fails;
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* tb/lunar_rescue_testdata.txt */
# w <addr> <data>: video RAM byte write; o <1|0>: overlay on or off
# s <sound_ctrl> <level>: sound bits and expected DAC level, all hex
w 0000 ff
w 001f 81
w 03e0 aa
w 0400 0f
w 07ff f0
w 0a10 01
w 0c05 80
w 0e1e 7e
w 1000 c3
w 1400 ff
w 17ff 18
w 1bff a5
o 1
o 0
s 00 00
s 01 28
s 03 50
s 15 78
s 0f a0
s 3e c8
s 3f f0

/* src.f */
hw/lunar_rescue_pkg.sv
hw/video_if.sv
hw/video_timing.sv
hw/video_ram.sv
hw/pixel_fetch.sv
hw/color_overlay.sv
hw/audio_out.sv
hw/lunar_rescue_top.sv
tb/lunar_rescue_checker.sv
tb/tb_lunar_rescue.sv
